//--- logic/depth_test.sv
/* depth interpolation and depth store */
module depth_test #(
    parameter int FB_TILES = 4
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_adv,
    input  logic                          i_valid,
    input  shader_geom_pkg::quad_pos_t    i_pos,
    input  shader_geom_pkg::tile_t        i_tile,
    input  shader_depth_pkg::depth_wr_t   i_wr,
    output logic [3:0]                    o_pass,
    output shader_depth_pkg::quad_depth_t o_depth
);
    import shader_geom_pkg::*;
    import shader_depth_pkg::*;

    localparam int TB      = $clog2(FB_TILES);
    localparam int IDX_W   = 2 * TB + 2;
    localparam int ENTRIES = FB_TILES * FB_TILES * 4;
    localparam int ZS_W    = DEPTH_W + 4;

    quad_depth_t             r_mem [ENTRIES];
    logic [ENTRIES-1:0][3:0] r_lvld;    // lanes written since reset
    logic [IDX_W-1:0]        w_rd_idx;
    logic [IDX_W-1:0]        w_wr_idx;
    quad_depth_t             w_rd;
    logic signed [ZS_W-1:0]  w_zs [LANES];
    quad_depth_t             w_z;
    logic                    r_v1;
    quad_depth_t             r_z;
    quad_depth_t             r_old;
    logic [3:0]              r_pass;
    quad_depth_t             r_depth;

    assign w_rd_idx = {i_pos.ty[TB-1:0], i_pos.tx[TB-1:0], i_pos.row};
    assign w_wr_idx = {i_wr.addr[6 +: TB], i_wr.addr[2 +: TB], i_wr.addr[1:0]};

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            w_rd[l] = r_lvld[w_rd_idx][l] ? r_mem[w_rd_idx][l] : DEPTH_FAR;
            w_zs[l] = ZS_W'(signed'({1'b0, i_tile.plane.z0}))
                    + ZS_W'(i_tile.plane.dzdx) * ZS_W'(l)
                    + ZS_W'(i_tile.plane.dzdy) * ZS_W'(signed'({1'b0, i_pos.row}));
            if (w_zs[l] < 0) begin
                w_z[l] = '0;
            end else if (w_zs[l] >= ZS_W'(signed'({1'b0, DEPTH_FAR}))) begin
                w_z[l] = DEPTH_FAR - 1'b1;   // far value stays reserved
            end else begin
                w_z[l] = w_zs[l][DEPTH_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            for (int l = 0; l < LANES; l++) begin
                if (i_wr.mask[l]) begin
                    r_mem[w_wr_idx][l] <= i_wr.z[l];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_lvld <= '0;
            r_v1   <= 1'b0;
        end else begin
            if (i_wr.en) begin
                r_lvld[w_wr_idx] <= r_lvld[w_wr_idx] | i_wr.mask;
            end
            if (i_adv) begin
                r_v1 <= i_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv && i_valid) begin   // stage 1
            r_z   <= w_z;
            r_old <= w_rd;
        end
        if (i_adv && r_v1) begin      // stage 2
            for (int l = 0; l < LANES; l++) begin
                r_pass[l] <= (r_z[l] < r_old[l]);
            end
            r_depth <= r_z;
        end
    end

    assign o_pass  = r_pass;
    assign o_depth = r_depth;

    // merge writes back the row that left stage 2, never the one entering
    wr_not_rd_row: assert property (@(posedge clk) disable iff (!rstn)
        i_wr.en && i_valid && i_adv |-> w_wr_idx != w_rd_idx);

endmodule

//--- logic/edge_coverage.sv
/* edge function coverage */
module edge_coverage (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_adv,
    input  logic                       i_valid,
    input  shader_geom_pkg::quad_pos_t i_pos,
    input  shader_geom_pkg::tile_t     i_tile,
    output logic                       o_valid,
    output shader_geom_pkg::quad_pos_t o_pos,
    output logic [3:0]                 o_cover
);
    import shader_geom_pkg::*;

    localparam int PROD_W = COEF_W + COORD_W + 1;

    logic                     r_v1;
    quad_pos_t                r_pos1;
    logic signed [PROD_W-1:0] r_ax [3][LANES];   // a*x per edge and lane
    logic signed [PROD_W-1:0] r_by [3];          // y is shared by the row
    logic signed [COEF_W-1:0] r_c  [3];
    logic signed [EDGE_W-1:0] w_edge [3][LANES];
    logic [LANES-1:0]         w_cov;
    logic                     r_v2;
    quad_pos_t                r_pos2;
    logic [LANES-1:0]         r_cover;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_v1 <= 1'b0;
            r_v2 <= 1'b0;
        end else if (i_adv) begin
            r_v1 <= i_valid;
            r_v2 <= r_v1;
        end
    end

    // stage 1, products
    always_ff @(posedge clk) begin
        if (i_adv) begin
            r_pos1 <= i_pos;
            for (int e = 0; e < 3; e++) begin
                for (int l = 0; l < LANES; l++) begin
                    r_ax[e][l] <= i_tile.edges[e].a
                                * signed'({1'b0, i_pos.px + COORD_W'(l)});
                end
                r_by[e] <= i_tile.edges[e].b * signed'({1'b0, i_pos.py});
                r_c[e]  <= i_tile.edges[e].c;
            end
        end
    end

    // stage 2, sums and sign test
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            for (int e = 0; e < 3; e++) begin
                w_edge[e][l] = EDGE_W'(r_ax[e][l]) + EDGE_W'(r_by[e]) + EDGE_W'(r_c[e]);
            end
            w_cov[l] = !w_edge[0][l][EDGE_W-1] && !w_edge[1][l][EDGE_W-1]
                    && !w_edge[2][l][EDGE_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_adv) begin
            r_pos2  <= r_pos1;
            r_cover <= w_cov;
        end
    end

    assign o_valid = r_v2;
    assign o_pos   = r_pos2;
    assign o_cover = r_cover;

endmodule

//--- logic/frag_shader_top.sv
/* tile fragment shader top */
module frag_shader_top #(
    parameter int FB_TILES = 4
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_tile_req,
    input  shader_geom_pkg::tile_t        i_tile,
    output logic                          o_tile_ack,
    output logic                          o_quad_req,
    input  logic                          i_quad_ack,
    output shader_geom_pkg::quad_pos_t    o_quad_pos,
    output logic [3:0]                    o_quad_mask,
    output shader_depth_pkg::quad_depth_t o_quad_depth
);
    import shader_geom_pkg::*;
    import shader_depth_pkg::*;

    logic        w_adv;   // output slot empty
    logic        w_tile_done;
    logic        w_s_valid;
    quad_pos_t   w_s_pos;
    tile_t       w_s_tile;
    logic        w_c_valid;
    quad_pos_t   w_c_pos;
    logic [3:0]  w_cover;
    logic [3:0]  w_pass;
    quad_depth_t w_depth;
    depth_wr_t   w_wr;

    quad_stepper u_stepper (
        .clk         (clk),
        .rstn        (rstn),
        .i_tile_req  (i_tile_req),
        .i_tile      (i_tile),
        .o_tile_ack  (o_tile_ack),
        .i_adv       (w_adv),
        .i_tile_done (w_tile_done),
        .o_valid     (w_s_valid),
        .o_pos       (w_s_pos),
        .o_tile      (w_s_tile)
    );

    edge_coverage u_cov (
        .clk     (clk),
        .rstn    (rstn),
        .i_adv   (w_adv),
        .i_valid (w_s_valid),
        .i_pos   (w_s_pos),
        .i_tile  (w_s_tile),
        .o_valid (w_c_valid),
        .o_pos   (w_c_pos),
        .o_cover (w_cover)
    );

    depth_test #(.FB_TILES(FB_TILES)) u_depth (
        .clk     (clk),
        .rstn    (rstn),
        .i_adv   (w_adv),
        .i_valid (w_s_valid),
        .i_pos   (w_s_pos),
        .i_tile  (w_s_tile),
        .i_wr    (w_wr),
        .o_pass  (w_pass),
        .o_depth (w_depth)
    );

    quad_merge u_merge (
        .clk          (clk),
        .rstn         (rstn),
        .i_cov_valid  (w_c_valid),
        .i_pos        (w_c_pos),
        .i_cover      (w_cover),
        .i_pass       (w_pass),
        .i_depth      (w_depth),
        .o_adv        (w_adv),
        .o_wr         (w_wr),
        .o_tile_done  (w_tile_done),
        .o_quad_req   (o_quad_req),
        .i_quad_ack   (i_quad_ack),
        .o_quad_pos   (o_quad_pos),
        .o_quad_mask  (o_quad_mask),
        .o_quad_depth (o_quad_depth)
    );

endmodule

//--- logic/quad_merge.sv
/* quad merge and output handshake */
module quad_merge (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_cov_valid,
    input  shader_geom_pkg::quad_pos_t    i_pos,
    input  logic [3:0]                    i_cover,
    input  logic [3:0]                    i_pass,
    input  shader_depth_pkg::quad_depth_t i_depth,
    output logic                          o_adv,
    output shader_depth_pkg::depth_wr_t   o_wr,
    output logic                          o_tile_done,
    output logic                          o_quad_req,
    input  logic                          i_quad_ack,
    output shader_geom_pkg::quad_pos_t    o_quad_pos,
    output logic [3:0]                    o_quad_mask,
    output shader_depth_pkg::quad_depth_t o_quad_depth
);
    import shader_geom_pkg::*;
    import shader_depth_pkg::*;

    logic        r_full;   // slot holds a quad
    logic        r_req;
    logic        r_done;
    logic        w_load;
    logic [3:0]  w_mask;
    quad_pos_t   r_pos;
    logic [3:0]  r_mask;
    quad_depth_t r_depth;

    assign w_load = i_cov_valid && !r_full;
    assign w_mask = i_cover & i_pass;

    // store written on the same edge the slot loads
    always_comb begin
        o_wr.en   = w_load;
        o_wr.addr = {i_pos.ty, i_pos.tx, i_pos.row};
        o_wr.mask = w_mask;
        o_wr.z    = i_depth;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_full <= 1'b0;
            r_req  <= 1'b0;
            r_done <= 1'b0;
        end else begin
            r_done <= 1'b0;
            if (!r_full) begin
                if (i_cov_valid) begin
                    r_full <= 1'b1;
                    r_req  <= 1'b1;
                end
            end else if (r_req) begin
                if (i_quad_ack) begin
                    r_req <= 1'b0;
                end
            end else if (!i_quad_ack) begin   // handshake complete
                r_full <= 1'b0;
                r_done <= r_pos.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_load) begin
            r_pos   <= i_pos;
            r_mask  <= w_mask;
            r_depth <= i_depth;
        end
    end

    assign o_adv        = !r_full;
    assign o_tile_done  = r_done;
    assign o_quad_req   = r_req;
    assign o_quad_pos   = r_pos;
    assign o_quad_mask  = r_mask;
    assign o_quad_depth = r_depth;

    req_held: assert property (@(posedge clk) disable iff (!rstn)
        o_quad_req && !i_quad_ack |=> o_quad_req);

endmodule

//--- logic/quad_stepper.sv
/* tile handshake and quad stepper */
module quad_stepper (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_tile_req,
    input  shader_geom_pkg::tile_t     i_tile,
    output logic                       o_tile_ack,
    input  logic                       i_adv,
    input  logic                       i_tile_done,
    output logic                       o_valid,
    output shader_geom_pkg::quad_pos_t o_pos,
    output shader_geom_pkg::tile_t     o_tile
);
    import shader_geom_pkg::*;

    tile_t      r_tile;
    logic [1:0] r_row;
    logic       r_ack;
    logic       r_busy;   // rows left to issue
    logic       r_wait;   // last quad still in flight
    logic       w_accept;

    assign w_accept = i_tile_req && !r_ack && !r_busy && !r_wait;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_ack  <= 1'b0;
            r_busy <= 1'b0;
            r_wait <= 1'b0;
            r_row  <= '0;
        end else begin
            if (w_accept) begin
                r_ack  <= 1'b1;
                r_busy <= 1'b1;
                r_row  <= '0;
            end else if (r_ack && !i_tile_req) begin
                r_ack <= 1'b0;
            end
            if (r_busy && i_adv) begin
                r_row <= r_row + 2'd1;
                if (r_row == 2'd3) begin
                    r_busy <= 1'b0;
                    r_wait <= 1'b1;
                end
            end
            if (r_wait && i_tile_done) begin
                r_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_accept) begin
            r_tile <= i_tile;
        end
    end

    always_comb begin
        o_pos.tx   = r_tile.tx;
        o_pos.ty   = r_tile.ty;
        o_pos.row  = r_row;
        o_pos.last = (r_row == 2'd3);
        o_pos.px   = COORD_W'({r_tile.tx, 2'b00});
        o_pos.py   = COORD_W'({r_tile.ty, r_row});
    end

    assign o_tile_ack = r_ack;
    assign o_valid    = r_busy;
    assign o_tile     = r_tile;

    // four-phase: ack only answers a raised request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        !i_tile_req && !o_tile_ack |=> !o_tile_ack);

endmodule

//--- logic/shader_depth_pkg.sv
/* depth plane and depth store types */
package shader_depth_pkg;

    localparam int DEPTH_W = 16;
    localparam logic [DEPTH_W-1:0] DEPTH_FAR = '1;   // empty store entry

    // store address layout is {tile y, tile x, row}
    localparam int WR_ADDR_W = 10;

    typedef struct packed {
        logic [DEPTH_W-1:0]        z0;     // depth at tile origin
        logic signed [DEPTH_W-1:0] dzdx;
        logic signed [DEPTH_W-1:0] dzdy;
    } depth_plane_t;

    // one depth per lane, lane 0 in the low bits
    typedef logic [3:0][DEPTH_W-1:0] quad_depth_t;

    typedef struct packed {
        logic                 en;
        logic [WR_ADDR_W-1:0] addr;
        logic [3:0]           mask;   // lanes to write
        quad_depth_t          z;
    } depth_wr_t;

endpackage

//--- logic/shader_geom_pkg.sv
/* tile and quad geometry types */
package shader_geom_pkg;

    localparam int LANES   = 4;    // samples per quad, rows per tile
    localparam int COORD_W = 8;
    localparam int COEF_W  = 16;
    localparam int EDGE_W  = 34;   // wide enough for a*x + b*y + c

    typedef struct packed {
        logic signed [COEF_W-1:0] a;
        logic signed [COEF_W-1:0] b;
        logic signed [COEF_W-1:0] c;
    } edge_coef_t;

    typedef struct packed {
        logic [3:0]                     tx;   // in tile units
        logic [3:0]                     ty;
        edge_coef_t [2:0]               edges;
        shader_depth_pkg::depth_plane_t plane;
    } tile_t;

    // position of one row of four samples
    typedef struct packed {
        logic [3:0]         tx;
        logic [3:0]         ty;
        logic [1:0]         row;
        logic               last;   // row 3 of the tile
        logic [COORD_W-1:0] px;     // pixel x of lane 0
        logic [COORD_W-1:0] py;
    } quad_pos_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, then search the log for the fail line
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_frag_shader -o tb_frag_shader \
    && ./obj_dir/tb_frag_shader 2>&1 | tee "$LOG" \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "TEST RESULT: FAIL" "$LOG" \
    && { echo "simulation failed, see $LOG"; exit 1; }

grep -q "TEST RESULT: PASS" "$LOG" \
    || { echo "no result line found in $LOG"; exit 1; }

echo "simulation passed"
exit 0

//--- sources.f
+incdir+verif
logic/shader_depth_pkg.sv
logic/shader_geom_pkg.sv
logic/quad_stepper.sv
logic/edge_coverage.sv
logic/depth_test.sv
logic/quad_merge.sv
logic/frag_shader_top.sv
verif/tb_frag_shader.sv

//--- verif/tb_model.svh
/* shader reference model */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int shadow [4][4][4][4];   // ty, tx, row, lane of the depth store

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
endfunction

function automatic longint edge_value(input edge_coef_t e, input longint x, input longint y);
    return longint'(e.a) * x + longint'(e.b) * y + longint'(e.c);
endfunction

// plane depth at one sample, kept inside 0 .. far-1
function automatic int lane_depth(input depth_plane_t p, input int lane, input int row);
    int z;
    z = int'(p.z0) + int'(p.dzdx) * lane + int'(p.dzdy) * row;
    if (z < 0) begin
        return 0;
    end
    if (z >= int'(DEPTH_FAR)) begin
        return int'(DEPTH_FAR) - 1;
    end
    return z;
endfunction

function automatic void clear_shadow();
    foreach (shadow[a, b, c, d]) begin
        shadow[a][b][c][d] = int'(DEPTH_FAR);
    end
endfunction

// expected mask and depths of one row, store updated for passing lanes
function automatic void expect_quad(input tile_t t, input int row,
                                    output logic [3:0] mask, output quad_depth_t z);
    int   x;
    int   y;
    int   d;
    int   sx;
    int   sy;
    logic cov;
    sx = int'(t.tx) % 4;
    sy = int'(t.ty) % 4;
    y  = 4 * int'(t.ty) + row;
    for (int l = 0; l < 4; l++) begin
        x   = 4 * int'(t.tx) + l;
        cov = edge_value(t.edges[0], longint'(x), longint'(y)) >= 0
           && edge_value(t.edges[1], longint'(x), longint'(y)) >= 0
           && edge_value(t.edges[2], longint'(x), longint'(y)) >= 0;
        d       = lane_depth(t.plane, l, row);
        z[l]    = DEPTH_W'(d);
        mask[l] = cov && (d < shadow[sy][sx][row][l]);
        if (mask[l]) begin
            shadow[sy][sx][row][l] = d;
        end
    end
endfunction

`endif

//--- verif/tb_frag_shader.sv
/* fragment shader testbench */
module tb_frag_shader;
    timeunit 1ns;
    timeprecision 1ps;

    import shader_geom_pkg::*;
    import shader_depth_pkg::*;

    localparam int N_TILES    = 10;
    localparam int MAX_CYCLES = N_TILES * 40;   // a tile takes under 40 cycles

    typedef struct packed {
        tile_t      tile;
        logic       fixed;   // every row must give the mask below
        logic [3:0] mask;
    } tile_case_t;

    logic        clk;
    logic        rstn;
    logic        tile_req;
    tile_t       tile;
    logic        tile_ack;
    logic        quad_req;
    logic        quad_ack;
    quad_pos_t   quad_pos;
    logic [3:0]  quad_mask;
    quad_depth_t quad_depth;

    tile_case_t  cases [N_TILES];
    logic [31:0] lfsr       = 32'h56db_6fba;
    int          cycle      = 0;
    int          errors     = 0;
    int          quads_seen = 0;
    int          tiles_done = 0;
    int          ack_cycle  = 0;

    `include "tb_model.svh"

    frag_shader_top #(.FB_TILES(4)) dut (
        .clk          (clk),
        .rstn         (rstn),
        .i_tile_req   (tile_req),
        .i_tile       (tile),
        .o_tile_ack   (tile_ack),
        .o_quad_req   (quad_req),
        .i_quad_ack   (quad_ack),
        .o_quad_pos   (quad_pos),
        .o_quad_mask  (quad_mask),
        .o_quad_depth (quad_depth)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles with %0d of %0d quads received",
                     cycle, quads_seen, 4 * N_TILES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    function automatic int next_ack_delay();
        int d;
        lfsr = lfsr_next(lfsr);
        d    = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        d    = 2 * d + int'(lfsr[0]);
        return d;
    endfunction

    function automatic edge_coef_t edge_of(input int a, input int b, input int c);
        edge_coef_t e;
        e.a = COEF_W'(a);
        e.b = COEF_W'(b);
        e.c = COEF_W'(c);
        return e;
    endfunction

    function automatic tile_case_t make_case(input int tx, input int ty, input edge_coef_t e0,
                                             input edge_coef_t e1, input edge_coef_t e2,
                                             input int z0, input int dzdx, input int dzdy,
                                             input logic fixed, input logic [3:0] mask);
        tile_case_t tc;
        tc.tile.tx         = 4'(tx);
        tc.tile.ty         = 4'(ty);
        tc.tile.edges[0]   = e0;
        tc.tile.edges[1]   = e1;
        tc.tile.edges[2]   = e2;
        tc.tile.plane.z0   = DEPTH_W'(z0);
        tc.tile.plane.dzdx = DEPTH_W'(dzdx);
        tc.tile.plane.dzdy = DEPTH_W'(dzdy);
        tc.fixed           = fixed;
        tc.mask            = mask;
        return tc;
    endfunction

    task automatic fill_table();
        edge_coef_t ex;
        edge_coef_t ey;
        edge_coef_t ed;
        edge_coef_t cut;
        edge_coef_t none;
        ex   = edge_of(1, 0, 0);       // x >= 0
        ey   = edge_of(0, 1, 0);       // y >= 0
        ed   = edge_of(-1, -1, 100);   // x + y <= 100
        cut  = edge_of(-1, 2, 2);      // diagonal through tile (1,0)
        none = edge_of(-1, 0, -1);
        cases[0] = make_case(0, 0, ex, ey, ed, 1000, 0, 0, 1'b1, 4'hf);
        cases[1] = make_case(1, 0, ex, ey, cut, 2000, 0, 0, 1'b0, 4'h0);
        cases[2] = make_case(0, 0, ex, ey, ed, 1500, 0, 0, 1'b1, 4'h0);   // behind
        cases[3] = make_case(0, 0, ex, ey, ed, 500, 0, 0, 1'b1, 4'hf);
        cases[4] = make_case(0, 0, ex, ey, ed, 700, 0, 0, 1'b1, 4'h0);    // store holds 500
        cases[5] = make_case(2, 1, ex, ey, ed, 1500, 300, -1000, 1'b1, 4'hf);
        cases[6] = make_case(3, 2, ex, ey, ed, 65000, 200, 100, 1'b1, 4'hf);
        cases[7] = make_case(1, 3, edge_of(3, -1, 0), edge_of(-1, 0, 6), edge_of(0, 1, -13),
                             40000, -5000, 3000, 1'b0, 4'h0);
        cases[8] = make_case(1, 0, ex, ey, ed, 1000, 1000, 0, 1'b0, 4'h0);
        cases[9] = make_case(3, 3, ex, ey, none, 1200, 0, 0, 1'b1, 4'h0);
    endtask

    initial begin : drive
        rstn     = 1'b0;
        tile_req = 1'b0;
        tile     = '0;
        quad_ack = 1'b0;
        fill_table();
        clear_shadow();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        if (tile_ack !== 1'b0) begin
            report_mismatch("o_tile_ack", 64'(tile_ack), 64'd0);
        end
        if (quad_req !== 1'b0) begin
            report_mismatch("o_quad_req", 64'(quad_req), 64'd0);
        end
        for (int i = 0; i < N_TILES; i++) begin
            tile     <= cases[i].tile;
            tile_req <= 1'b1;
            @(posedge clk);
            while (tile_ack !== 1'b1) begin
                @(posedge clk);
            end
            ack_cycle = cycle;
            if (tiles_done != i) begin
                report_fault($sformatf("tile %0d acknowledged before tile %0d finished",
                                       i, i - 1));
            end
            tile_req <= 1'b0;
            @(posedge clk);
            while (tile_ack !== 1'b0) begin
                @(posedge clk);
            end
        end
        while (tiles_done < N_TILES) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);   // room for a stray extra quad
        if (quads_seen != 4 * N_TILES) begin
            report_fault($sformatf("%0d quads received instead of %0d",
                                   quads_seen, 4 * N_TILES));
        end
        $display("checked %0d quads of %0d tiles, %0d errors", quads_seen, N_TILES, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // quad side, checks each quad then acks after a random delay
    initial begin : receive
        int          tidx;
        int          row;
        int          delay;
        tile_t       t;
        quad_pos_t   exp_pos;
        logic [3:0]  exp_mask;
        quad_depth_t exp_depth;
        wait (rstn === 1'b1);
        forever begin
            @(posedge clk);
            if (quad_req === 1'b1) begin
                tidx = quads_seen / 4;
                row  = quads_seen % 4;
                if (tidx >= N_TILES) begin
                    report_fault("quad received after the last tile");
                end else begin
                    t            = cases[tidx].tile;
                    exp_pos.tx   = t.tx;
                    exp_pos.ty   = t.ty;
                    exp_pos.row  = 2'(row);
                    exp_pos.last = (row == 3);
                    exp_pos.px   = COORD_W'(4 * int'(t.tx));
                    exp_pos.py   = COORD_W'(4 * int'(t.ty) + row);
                    expect_quad(t, row, exp_mask, exp_depth);
                    if (quad_pos !== exp_pos) begin
                        report_mismatch("o_quad_pos", 64'(quad_pos), 64'(exp_pos));
                    end
                    if (quad_mask !== exp_mask) begin
                        report_mismatch("o_quad_mask", 64'(quad_mask), 64'(exp_mask));
                    end
                    if (cases[tidx].fixed && quad_mask !== cases[tidx].mask) begin
                        report_mismatch("o_quad_mask (table)", 64'(quad_mask),
                                        64'(cases[tidx].mask));
                    end
                    if (quad_depth !== exp_depth) begin
                        report_mismatch("o_quad_depth", 64'(quad_depth), 64'(exp_depth));
                    end
                    if (row == 0 && cycle - ack_cycle != 3) begin
                        report_fault($sformatf("first quad of tile %0d came %0d cycles after ack",
                                               tidx, cycle - ack_cycle));
                    end
                end
                quads_seen++;
                delay = next_ack_delay();
                repeat (delay) @(posedge clk);
                quad_ack <= 1'b1;
                @(posedge clk);
                while (quad_req === 1'b1) begin
                    @(posedge clk);
                end
                quad_ack <= 1'b0;
                if (quad_pos.last) begin
                    tiles_done++;
                end
            end
        end
    end

endmodule
